/* include/tb_model.svh */
// testbench reference model of the mono raster, included inside the testbench module
// memory content is a fixed mix of the word address, no real memory is held
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// one mask bit per lfsr step
function automatic logic [15:0] make_mask(input logic [31:0] seed);
	logic [31:0] s;
	logic [15:0] m;
	s = seed;
	m = '0;
	for (int i = 0; i < 16; i++) begin
		s = lfsr_next(s);
		m[i] = s[0];
	end
	return m;
endfunction

// memory word at a word address, every address bit reaches the data
function automatic logic [15:0] model_word(input logic [22:0] a, input logic [15:0] mask);
	return a[15:0] ^ {a[8:0], a[22:16]} ^ mask;
endfunction

// pixel n of the frame, msb of each word first
function automatic logic expected_pixel(
	input logic [22:0] base,
	input int          n,
	input logic        inv,
	input logic [15:0] mask
);
	logic [15:0] w;
	int          bit_idx;
	w = model_word(base + 23'(n / 16), mask);
	bit_idx = 15 - (n % 16);
	return w[bit_idx] ^ inv;
endfunction

// palette register layout as seen on the data bus
function automatic logic [15:0] pal_word(input logic [2:0] r, g, b);
	return {5'd0, r, 1'b0, g, 1'b0, b};
endfunction

`endif

/* dv/tb_video.sv */
// drives the mono video top through two frames with a modelled memory
// bus_cycle is held at 15 in reset so read stays low until release
`include "video_defs.svh"

module tb_video;
	import video_pkg::*;
	`include "tb_model.svh"

	localparam int FRAME_PIX = `H_ACT * `V_ACT;
	localparam int LINE_CLK = `H_TOT;
	localparam int TIMEOUT = 500000;

	logic clk, ss, bus_run, timed_out;
	reg_bus_t reg_bus;
	slot_t bus_cycle;
	word_t data, reg_dout, mask, rd;
	logic read;
	vaddr_t vaddr, exp_base, e_addr;
	screen_t screen;
	logic exp_inv, exp_pix, hs_prev, vs_prev, read_seen, de_seen;
	int errors, tests, failed, first_err;
	int n_de, hs_falls, hs_low, vs_low, vs_falls, snap_hs_falls, snap_vs_low;

	video_top i_dut (
		.clk       (clk),
		.ss        (ss),
		.reg_bus   (reg_bus),
		.bus_cycle (bus_cycle),
		.data      (data),
		.reg_dout  (reg_dout),
		.read      (read),
		.vaddr     (vaddr),
		.screen    (screen)
	);

	always #20 clk = !clk;

	// slot counter, starts at 0 in the first clock after release
	always @(posedge clk) begin
		if (bus_run) #2 bus_cycle = bus_cycle + 4'd1;
	end

	// memory answers every clock for the current word address
	always @(posedge clk) begin
		#2 data = model_word(vaddr, mask);
	end

	task automatic report_value(input string name, input int expected, input int got);
		errors++;
		$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, got);
	endtask

	// compare process, every de cycle against the model
	always @(negedge clk) begin
		if (!ss) begin
			// pixel index restarts in every vsync, de is low there
			if (!screen.vs) n_de = 0;
			if (screen.de) begin
				exp_pix = expected_pixel(exp_base, n_de, exp_inv, mask);
				if (screen.r != {6{exp_pix}}) report_value("screen.r", {6{exp_pix}}, screen.r);
				if (screen.g != {6{exp_pix}}) report_value("screen.g", {6{exp_pix}}, screen.g);
				if (screen.b != {6{exp_pix}}) report_value("screen.b", {6{exp_pix}}, screen.b);
				n_de++;
			end else if ((screen.r | screen.g | screen.b) != 0) begin
				report_value("screen.r|g|b outside de", 0, screen.r | screen.g | screen.b);
			end
		end
	end

	// sync monitor, hs widths, vs length, read on lines without de
	always @(negedge clk) begin
		if (!ss) begin
			if (read) read_seen = 1'b1;
			if (screen.de) de_seen = 1'b1;
			if (hs_prev && !screen.hs) begin
				hs_falls++;
				// one hsync per line, so each fall closes a line
				if (read_seen && !de_seen) begin
					errors++;
					$display("read strobe high at %0t in a line without de", $time);
				end
				read_seen = 1'b0;
				de_seen = 1'b0;
			end
			if (!screen.hs) hs_low++;
			if (!hs_prev && screen.hs) begin
				if (hs_low != `H_S) report_value("hs low width", `H_S, hs_low);
				hs_low = 0;
			end
			if (vs_prev && !screen.vs) begin
				snap_hs_falls = hs_falls;
				hs_falls = 0;
				vs_falls++;
			end
			if (!screen.vs) vs_low++;
			if (!vs_prev && screen.vs) begin
				snap_vs_low = vs_low;
				vs_low = 0;
			end
			hs_prev = screen.hs;
			vs_prev = screen.vs;
		end
	end

	task automatic step;
		@(posedge clk);
		#2;
	endtask

	task automatic write_reg(input reg_addr_t a, input word_t d, input logic u, input logic l);
		reg_bus.sel = 1'b1;
		reg_bus.rw = 1'b0;
		reg_bus.addr = a;
		reg_bus.din = d;
		reg_bus.uds = u;
		reg_bus.lds = l;
		step();
		reg_bus.sel = 1'b0;
		reg_bus.rw = 1'b1;
		reg_bus.uds = 1'b1;
		reg_bus.lds = 1'b1;
	endtask

	// read is combinational, taken 10 units after driving
	task automatic check_reg(input string name, input reg_addr_t a, input word_t expected);
		reg_bus.sel = 1'b1;
		reg_bus.rw = 1'b1;
		reg_bus.addr = a;
		reg_bus.uds = 1'b0;
		reg_bus.lds = 1'b0;
		#10;
		rd = reg_dout;
		reg_bus.sel = 1'b0;
		reg_bus.uds = 1'b1;
		reg_bus.lds = 1'b1;
		if (rd != expected) report_value(name, expected, rd);
	endtask

	task automatic wait_de_total(input int target);
		int t;
		t = 0;
		while (n_de != target && t < TIMEOUT && !timed_out) begin
			step();
			t++;
		end
		if (n_de != target && !timed_out) begin
			timed_out = 1'b1;
			$display("timeout, the de count never reached %0d", target);
		end
	endtask

	task automatic wait_vs_falls(input int target);
		int t;
		t = 0;
		while (vs_falls < target && t < TIMEOUT && !timed_out) begin
			step();
			t++;
		end
		if (vs_falls < target && !timed_out) begin
			timed_out = 1'b1;
			$display("timeout, vsync number %0d never started", target);
		end
	endtask

	task automatic wait_lines(input int lines);
		for (int i = 0; i < lines * LINE_CLK; i++) step();
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != first_err) failed++;
		$display("test %s: %s, %0d mismatches", name,
			(errors == first_err) ? "ok" : "FAILED", errors - first_err);
		first_err = errors;
	endtask

	initial begin
		clk = 1'b0;
		ss = 1'b1;
		bus_run = 1'b0;
		bus_cycle = 4'hf;
		data = '0;
		reg_bus = '0;
		reg_bus.rw = 1'b1;
		reg_bus.uds = 1'b1;
		reg_bus.lds = 1'b1;
		{timed_out, errors, tests, failed, first_err} = '0;
		{n_de, hs_falls, hs_low, vs_low, vs_falls, snap_hs_falls, snap_vs_low} = '0;
		read_seen = 1'b0;
		de_seen = 1'b0;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		mask = make_mask(32'hf531);
		exp_base = `BASE_DEFAULT;
		exp_inv = (`PAL0_DEFAULT & 9'h001) != 9'h000;

		// outputs checked while reset is still held
		repeat (15) step();
		if (screen.hs !== 1'b1) report_value("screen.hs", 1, screen.hs);
		if (screen.vs !== 1'b1) report_value("screen.vs", 1, screen.vs);
		if (screen.de !== 1'b0) report_value("screen.de", 0, screen.de);
		if (read !== 1'b0) report_value("read", 0, read);
		check_reg("base hi", `REG_BASE_HI, 16'(exp_base[22:15]));
		check_reg("base lo", `REG_BASE_LO, 16'(exp_base[14:7]));
		check_reg("palette 0", `REG_PAL0, pal_word(3'(`PAL0_DEFAULT >> 6),
			3'(`PAL0_DEFAULT >> 3), 3'(`PAL0_DEFAULT)));
		step();
		ss = 1'b0;
		bus_cycle = 4'd0;
		bus_run = 1'b1;
		end_test("reset");

		// byte strobes, blue bit 0 kept set so the frame stays inverted
		write_reg(`REG_BASE_HI, 16'h005a, 1'b1, 1'b0);
		check_reg("base hi", `REG_BASE_HI, 16'h005a);
		write_reg(`REG_BASE_LO, 16'h00c3, 1'b0, 1'b1);
		check_reg("base lo unstrobed", `REG_BASE_LO, 16'(exp_base[14:7]));
		write_reg(`REG_BASE_LO, 16'h00c3, 1'b1, 1'b0);
		check_reg("base lo", `REG_BASE_LO, 16'h00c3);
		write_reg(`REG_PAL0, 16'h0500, 1'b0, 1'b1);
		check_reg("palette 0 upper", `REG_PAL0, pal_word(3'd5, 3'(`PAL0_DEFAULT >> 3),
			3'(`PAL0_DEFAULT)));
		write_reg(`REG_PAL0, 16'h0035, 1'b1, 1'b0);
		check_reg("palette 0 lower", `REG_PAL0, pal_word(3'd5, 3'd3, 3'd5));
		reg_bus.sel = 1'b0;
		reg_bus.uds = 1'b0;
		reg_bus.lds = 1'b0;
		#10;
		if (reg_dout != 16'h0000) report_value("reg_dout with sel low", 0, reg_dout);
		reg_bus.uds = 1'b1;
		reg_bus.lds = 1'b1;
		end_test("register access");

		wait_de_total(FRAME_PIX);
		// front porch, no more de may follow
		if (!timed_out) wait_lines(2);
		if (n_de != FRAME_PIX) report_value("de cycles in frame 1", FRAME_PIX, n_de);
		end_test("first frame");

		e_addr = exp_base + 23'(`WORDS_PER_LINE) * 23'(`V_ACT);
		check_reg("vaddr hi", `REG_VADDR_HI, 16'(e_addr[22:15]));
		check_reg("vaddr mid", `REG_VADDR_MID, 16'(e_addr[14:7]));
		check_reg("vaddr lo", `REG_VADDR_LO, 16'({e_addr[6:0], 1'b0}));
		end_test("address read-back");

		// base must be in place before the reload at vsync entry
		write_reg(`REG_BASE_HI, 16'h0012, 1'b1, 1'b0);
		write_reg(`REG_BASE_LO, 16'h0034, 1'b1, 1'b0);
		wait_vs_falls(1);
		write_reg(`REG_PAL0, 16'h0030, 1'b1, 1'b0);
		check_reg("palette 0 cleared invert", `REG_PAL0, pal_word(3'd5, 3'd3, 3'd0));
		exp_base = {8'h12, 8'h34, 7'd0};
		exp_inv = 1'b0;
		wait_de_total(FRAME_PIX);
		if (!timed_out) wait_lines(2);
		if (n_de != FRAME_PIX) report_value("de cycles in frame 2", FRAME_PIX, n_de);
		end_test("new base and inversion");

		wait_vs_falls(2);
		if (snap_hs_falls != 531) report_value("hs falls per frame", 531, snap_hs_falls);
		if (snap_vs_low != `V_S * LINE_CLK)
			report_value("vs low cycles", `V_S * LINE_CLK, snap_vs_low);
		end_test("sync counts");

		if (timed_out) $display("run stopped early by a timeout");
		$display("%0d tests, %0d failed, %0d mismatches in total", tests, failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+include
hdl/video_pkg.sv
hdl/video_timer.sv
hdl/frame_fsm.sv
hdl/video_regs.sv
hdl/fetch_unit.sv
hdl/mono_shifter.sv
hdl/video_top.sv
dv/tb_video.sv

/* hdl/fetch_unit.sv */
// video memory fetch, one word per 16 clock slot during active lines
// memory must return data in the sample slot, there is no wait state
`include "video_defs.svh"

module fetch_unit (
	input  logic              clk,
	input  logic              ss,
	input  video_pkg::pix_cnt_t hcnt,
	input  logic              active_lines,
	input  logic              frame_reload,
	input  video_pkg::slot_t  bus_cycle,
	input  video_pkg::word_t  data,
	input  video_pkg::vaddr_t base,
	output logic              read,
	output video_pkg::vaddr_t vaddr,
	output video_pkg::word_t  fetched
);
	import video_pkg::*;

	logic sample;

	// video owns slots 0..3 of every 16, runs H_PRE ahead of de
	assign read = (bus_cycle[3:2] == 2'b00) && (hcnt < `H_ACT) && active_lines;

	// data valid on the bus in this slot
	assign sample = read && (bus_cycle == `SLOT_SAMPLE);

	// address counter
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			vaddr <= `BASE_DEFAULT;
		end else if (frame_reload) begin
			// new base only takes effect here, once per frame
			vaddr <= base;
		end else if (sample) begin
			vaddr <= vaddr + 23'd1;
		end
	end

	// word holding register for the shifter
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			fetched <= '0;
		end else if (sample) begin
			fetched <= data;
		end
	end

endmodule

/* hdl/frame_fsm.sv */
// vertical phase sequencer, 531 lines per frame
// starts in the active phase, so the first frame is shown right after reset
module frame_fsm (
	input  logic                clk,
	input  logic                ss,
	input  logic                line_end,
	input  logic                phase_end,
	output video_pkg::v_phase_t phase,
	output logic                active_lines,
	output logic                vs_act,
	output logic                frame_reload
);
	import video_pkg::*;

	v_phase_t next_phase;
	logic     advance;

	// phase change only at a line boundary
	assign advance = line_end && phase_end;

	// fixed order active, front, sync, back
	always_comb begin
		case (phase)
			v_active: next_phase = v_front;
			v_front:  next_phase = v_sync;
			v_sync:   next_phase = v_back;
			default:  next_phase = v_active;
		endcase
	end

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			phase <= v_active;
		end else if (advance) begin
			phase <= next_phase;
		end
	end

	// one clock, coincides with the first clock of v_sync
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			frame_reload <= 1'b0;
		end else begin
			frame_reload <= advance && (next_phase == v_sync);
		end
	end

	// levels decoded straight from the state
	assign active_lines = (phase == v_active);
	assign vs_act = (phase == v_sync);

endmodule

/* hdl/mono_shifter.sv */
// hires mono pixel shifter and registered screen outputs
// all screen fields lag hcnt by one clock
`include "video_defs.svh"

module mono_shifter (
	input  logic                clk,
	input  logic                ss,
	input  video_pkg::pix_cnt_t hcnt,
	input  logic                active_lines,
	input  logic                hs_act,
	input  logic                vs_act,
	input  logic                invert,
	input  video_pkg::word_t    fetched,
	output video_pkg::screen_t  screen
);
	import video_pkg::*;

	word_t   shreg;
	logic    pixel;
	logic    de_win;
	colour_t pix_col;

	// reload at end of each 16 clock group, else msb first
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			shreg <= '0;
		end else if (hcnt[3:0] == 4'hf) begin
			shreg <= fetched;
		end else begin
			shreg <= {shreg[14:0], 1'b0};
		end
	end

	// palette 0 blue bit 0 flips black and white
	assign pixel = shreg[15] ^ invert;

	// visible window, delayed by the prefetch lead
	assign de_win = (hcnt >= `H_PRE) && (hcnt < `H_PRE + `H_ACT) && active_lines;

	// grey level, all 6 bits the same
	assign pix_col = {6{pixel}};

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			screen.hs <= 1'b1;
			screen.vs <= 1'b1;
			screen.de <= 1'b0;
			screen.r <= '0;
			screen.g <= '0;
			screen.b <= '0;
		end else begin
			// syncs are negative
			screen.hs <= !hs_act;
			screen.vs <= !vs_act;
			screen.de <= de_win;
			// black outside the window
			screen.r <= de_win ? pix_col : '0;
			screen.g <= de_win ? pix_col : '0;
			screen.b <= de_win ? pix_col : '0;
		end
	end

endmodule

/* hdl/video_pkg.sv */
// shared types of the mono video path
// widths follow the 23-bit word address and 16-bit data bus
package video_pkg;

	typedef logic [15:0] word_t;
	typedef logic [22:0] vaddr_t;
	typedef logic [9:0]  pix_cnt_t;
	typedef logic [9:0]  line_cnt_t;
	typedef logic [5:0]  reg_addr_t;
	typedef logic [3:0]  slot_t;
	typedef logic [5:0]  colour_t;

	// 3 bits per channel, same layout as the register
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} palette_t;

	// vertical phases in frame order
	typedef enum logic [1:0] {
		v_active,
		v_front,
		v_sync,
		v_back
	} v_phase_t;

	// cpu side, strobes active low like the 68k bus
	typedef struct packed {
		logic      sel;
		logic      rw;
		logic      uds;
		logic      lds;
		reg_addr_t addr;
		word_t     din;
	} reg_bus_t;

	// syncs active low
	typedef struct packed {
		logic    hs;
		logic    vs;
		logic    de;
		colour_t r;
		colour_t g;
		colour_t b;
	} screen_t;

endpackage

/* hdl/video_regs.sv */
// cpu registers for video base and palette 0, written on clk while sel and !rw
// base low 7 bits are fixed zero, reads are combinational
`include "video_defs.svh"

module video_regs (
	input  logic                clk,
	input  logic                ss,
	input  video_pkg::reg_bus_t reg_bus,
	input  video_pkg::vaddr_t   vaddr,
	output video_pkg::vaddr_t   base,
	output video_pkg::palette_t pal0,
	output video_pkg::word_t    reg_dout
);
	import video_pkg::*;

	// base address bits 22:15 and 14:7
	logic [7:0] base_hi;
	logic [7:0] base_lo;
	logic       wr_en;
	logic       rd_en;

	assign wr_en = reg_bus.sel && !reg_bus.rw;
	assign rd_en = reg_bus.sel && reg_bus.rw;

	// 128 word granularity
	assign base = {base_hi, base_lo, 7'd0};

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			base_hi <= 8'(`BASE_DEFAULT >> 15);
			base_lo <= 8'(`BASE_DEFAULT >> 7);
			pal0 <= `PAL0_DEFAULT;
		end else if (wr_en) begin
			// byte registers sit on the low byte lane
			if (reg_bus.addr == `REG_BASE_HI && !reg_bus.lds) begin
				base_hi <= reg_bus.din[7:0];
			end
			if (reg_bus.addr == `REG_BASE_LO && !reg_bus.lds) begin
				base_lo <= reg_bus.din[7:0];
			end
			if (reg_bus.addr == `REG_PAL0) begin
				// red in the upper byte
				if (!reg_bus.uds) begin
					pal0.r <= reg_bus.din[10:8];
				end
				// green and blue in the lower byte
				if (!reg_bus.lds) begin
					pal0.g <= reg_bus.din[6:4];
					pal0.b <= reg_bus.din[2:0];
				end
			end
		end
	end

	// read back mux, zero when nothing selected
	always_comb begin
		reg_dout = '0;
		if (rd_en) begin
			case (reg_bus.addr)
				`REG_BASE_HI: begin
					if (!reg_bus.lds) reg_dout[7:0] = base[22:15];
				end
				`REG_BASE_LO: begin
					if (!reg_bus.lds) reg_dout[7:0] = base[14:7];
				end
				// running address, lets the cpu follow the beam
				`REG_VADDR_HI: begin
					if (!reg_bus.lds) reg_dout[7:0] = vaddr[22:15];
				end
				`REG_VADDR_MID: begin
					if (!reg_bus.lds) reg_dout[7:0] = vaddr[14:7];
				end
				// byte address view, so bit 0 is zero
				`REG_VADDR_LO: begin
					if (!reg_bus.lds) reg_dout[7:0] = {vaddr[6:0], 1'b0};
				end
				`REG_PAL0: begin
					if (!reg_bus.uds) reg_dout[10:8] = pal0.r;
					if (!reg_bus.lds) reg_dout[6:4] = pal0.g;
					if (!reg_bus.lds) reg_dout[2:0] = pal0.b;
				end
				default: reg_dout = '0;
			endcase
		end
	end

endmodule

/* hdl/video_timer.sv */
// horizontal counter and per-phase line counter
// hcnt is expected to stay aligned with bus_cycle from reset release
`include "video_defs.svh"

module video_timer (
	input  logic                clk,
	input  logic                ss,
	input  video_pkg::v_phase_t phase,
	output video_pkg::pix_cnt_t hcnt,
	output logic                line_end,
	output logic                phase_end,
	output logic                hs_act
);
	import video_pkg::*;

	// line number inside the current vertical phase
	line_cnt_t lcnt;
	// number of lines of the current phase
	line_cnt_t phase_len;

	always_comb begin
		case (phase)
			v_active: phase_len = `V_ACT;
			v_front:  phase_len = `V_FP;
			v_sync:   phase_len = `V_S;
			default:  phase_len = `V_BP;
		endcase
	end

	// last clock of a line
	assign line_end = (hcnt == `H_TOT - 10'd1);
	// last clock of the last line of this phase
	assign phase_end = line_end && (lcnt == phase_len - 10'd1);

	// hsync window, shifted by the prefetch lead like de
	assign hs_act = (hcnt >= `H_PRE + `H_ACT + `H_FP) &&
		(hcnt < `H_PRE + `H_ACT + `H_FP + `H_S);

	// pixel counter, wraps once per line
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			hcnt <= '0;
		end else if (line_end) begin
			hcnt <= '0;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	// line counter restarts with every new phase
	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			lcnt <= '0;
		end else if (phase_end) begin
			lcnt <= '0;
		end else if (line_end) begin
			lcnt <= lcnt + 10'd1;
		end
	end

endmodule

/* hdl/video_top.sv */
// mono 640x400 video shifter, single clock
// bus_cycle must equal hcnt[3:0], i.e. be 0 in the first clock after reset
module video_top (
	input  logic                clk,
	input  logic                ss,
	input  video_pkg::reg_bus_t reg_bus,
	input  video_pkg::slot_t    bus_cycle,
	input  video_pkg::word_t    data,
	output video_pkg::word_t    reg_dout,
	output logic                read,
	output video_pkg::vaddr_t   vaddr,
	output video_pkg::screen_t  screen
);
	import video_pkg::*;

	// timing
	pix_cnt_t hcnt;
	logic     line_end;
	logic     phase_end;
	logic     hs_act;

	// vertical state
	v_phase_t phase;
	logic     active_lines;
	logic     vs_act;
	logic     frame_reload;

	// registers and fetch data
	vaddr_t   base;
	palette_t pal0;
	word_t    fetched;

	video_timer i_timer (
		.clk       (clk),
		.ss        (ss),
		.phase     (phase),
		.hcnt      (hcnt),
		.line_end  (line_end),
		.phase_end (phase_end),
		.hs_act    (hs_act)
	);

	frame_fsm i_frame (
		.clk          (clk),
		.ss           (ss),
		.line_end     (line_end),
		.phase_end    (phase_end),
		.phase        (phase),
		.active_lines (active_lines),
		.vs_act       (vs_act),
		.frame_reload (frame_reload)
	);

	video_regs i_regs (
		.clk      (clk),
		.ss       (ss),
		.reg_bus  (reg_bus),
		.vaddr    (vaddr),
		.base     (base),
		.pal0     (pal0),
		.reg_dout (reg_dout)
	);

	// base is picked up at frame_reload only
	fetch_unit i_fetch (
		.clk          (clk),
		.ss           (ss),
		.hcnt         (hcnt),
		.active_lines (active_lines),
		.frame_reload (frame_reload),
		.bus_cycle    (bus_cycle),
		.data         (data),
		.base         (base),
		.read         (read),
		.vaddr        (vaddr),
		.fetched      (fetched)
	);

	// invert from palette 0 blue lsb
	mono_shifter i_shifter (
		.clk          (clk),
		.ss           (ss),
		.hcnt         (hcnt),
		.active_lines (active_lines),
		.hs_act       (hs_act),
		.vs_act       (vs_act),
		.invert       (pal0.b[0]),
		.fetched      (fetched),
		.screen       (screen)
	);

endmodule

/* include/video_defs.svh */
// fixed 640x400 mono raster, one clock per pixel, one bus slot per 16 clocks
// horizontal and vertical values are sized to the 10-bit counters
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// horizontal timing in clocks
// prefetch lead, fetch runs this far ahead of de
`define H_PRE          10'd16
`define H_ACT          10'd640
`define H_FP           10'd24
`define H_S            10'd40
`define H_BP           10'd128
`define H_TOT          (`H_ACT + `H_FP + `H_S + `H_BP)

// vertical timing in lines
`define V_ACT          10'd400
`define V_FP           10'd55
`define V_S            10'd3
`define V_BP           10'd73

// fetch
`define WORDS_PER_LINE 6'd40
// slot in which memory data is valid
`define SLOT_SAMPLE    4'd3

// reset values
`define BASE_DEFAULT   23'h8000
`define PAL0_DEFAULT   9'h007

// cpu register map
`define REG_BASE_HI    6'h00
`define REG_BASE_LO    6'h01
`define REG_VADDR_HI   6'h02
`define REG_VADDR_MID  6'h03
`define REG_VADDR_LO   6'h04
`define REG_PAL0       6'h20

`endif

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_video \
	-Mdir obj_dir -o sim_video &&
./obj_dir/sim_video | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{
	echo "simulation failed"
	exit 1
}
